// ==== Makefile ====
SIM       = verilator
TOP       = aesPipelineTb
FILELIST  = verilog.f
OBJDIR    = obj_dir
LINTFLAGS = --lint-only --timing --assert
SIMFLAGS  = --binary --timing --assert -j 0
RUNFLAGS  = +verilator+error+limit+1000
PASSMSG   = Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP) $(RUNFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)

// ==== aesFinalStage.sv ====
`default_nettype none
`timescale 1ns/100ps

module aesFinalStage
    import aesPkg::*;
(
    input  logic       clk,
    input  aesStageBus stageIn,
    output aesBlock    cipherText
);

    aesWord [0:3] stCols;
    aesWord [0:3] keyCols;
    aesWord [0:3] keyChain;
    aesWord [0:3] keyChainQ;
    aesWord       subRotQ;
    aesWord [0:3] subStateQ;
    aesWord [0:3] newKey;
    aesWord [0:3] shifted;

    assign stCols  = stageIn.state;
    assign keyCols = stageIn.roundKey;

    // Last key step uses the tenth round constant
    always_comb begin
        keyChain[0] = keyCols[0] ^ {roundConst(NumRounds), 24'h000000};
        keyChain[1] = keyChain[0] ^ keyCols[1];
        keyChain[2] = keyChain[1] ^ keyCols[2];
        keyChain[3] = keyChain[2] ^ keyCols[3];
    end

    always_ff @(posedge clk) begin
        keyChainQ <= keyChain;
        subRotQ   <= subWord(rotWord(keyCols[3]));
        for (int c = 0; c < 4; c++) begin
            subStateQ[c] <= subWord(stCols[c]);
        end
    end

    // ShiftRows only, no MixColumns in the last round
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            newKey[c]  = keyChainQ[c] ^ subRotQ;
            shifted[c] = {subStateQ[c][0], subStateQ[(c + 1) % 4][1],
                          subStateQ[(c + 2) % 4][2], subStateQ[(c + 3) % 4][3]};
        end
    end

    always_ff @(posedge clk) begin
        cipherText <= shifted ^ newKey;
    end

endmodule

`default_nettype wire

// ==== aesInputStage.sv ====
`default_nettype none
`timescale 1ns/100ps

module aesInputStage
    import aesPkg::*;
(
    input  logic       clk,
    input  aesBlock    plainText,
    input  aesBlock    cipherKey,
    output aesStageBus stageOut
);

    // Initial AddRoundKey, key travels beside its block from here on
    always_ff @(posedge clk) begin
        stageOut.state    <= plainText ^ cipherKey;
        stageOut.roundKey <= cipherKey;
    end

endmodule

`default_nettype wire

// ==== aesPipeline.sv ====
`default_nettype none
`timescale 1ns/100ps

module aesPipeline
    import aesPkg::*;
(
    input  logic    clk,
    input  aesBlock plainText,
    input  aesBlock cipherKey,
    output aesBlock cipherText
);

    // Bus i carries the state after round i and its round key
    aesStageBus stageBus [NumRounds];

    aesInputStage inputStage (
        .clk       (clk),
        .plainText (plainText),
        .cipherKey (cipherKey),
        .stageOut  (stageBus[0])
    );

    ////////////////////////////////////////////////////////////////////
    // Rounds 1 to 9
    ////////////////////////////////////////////////////////////////////

    for (genvar i = 1; i < NumRounds; i++) begin : gRound
        aesRoundStage #(
            .RoundIdx (i)
        ) roundStage (
            .clk      (clk),
            .stageIn  (stageBus[i - 1]),
            .stageOut (stageBus[i])
        );
    end

    aesFinalStage finalStage (
        .clk        (clk),
        .stageIn    (stageBus[NumRounds - 1]),
        .cipherText (cipherText)
    );

endmodule

`default_nettype wire

// ==== aesPipelineTb.sv ====
`default_nettype none
`timescale 1ns/100ps

module aesPipelineTb
    import aesPkg::*;
();

    localparam int NumTests = 6;
    localparam int Watchdog = NumTests * (PipeLatency + 40) + 16;

    logic        clk;
    logic        rst;
    aesBlock     plainText;
    aesBlock     cipherKey;
    aesBlock     cipherText;
    logic [31:0] lfsrState;
    int          testsPassed;
    int          testsFailed;

    // Idle input between tests, distinct from every known-answer vector
    localparam aesBlock IdleBlock = '1;

    aesPipeline uut (
        .clk        (clk),
        .plainText  (plainText),
        .cipherKey  (cipherKey),
        .cipherText (cipherText)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
    end

    initial begin
        repeat (Watchdog) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", Watchdog);
        $display("Verification failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic randomBits(input int count, output logic [127:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            bits = {bits[126:0], lfsrState[0]};
        end
    endtask

    task automatic checkOutput(input string name, input aesBlock expected, inout logic ok);
        assert (cipherText === expected) else begin
            $display("Fail %s: expected %h, actual %h", name, expected, cipherText);
            ok = 1'b0;
        end
    endtask

    task automatic finishTest(input string name, input logic ok);
        if (ok) begin
            testsPassed++;
            $display("Test %s passed", name);
        end else begin
            testsFailed++;
            $display("Test %s failed", name);
        end
    endtask

    task automatic driveInputs(input aesBlock pt, input aesBlock key, input int cycles);
        @(posedge clk);
        plainText <= pt;
        cipherKey <= key;
        repeat (cycles - 1) @(posedge clk);
    endtask

    // One vector, result expected exactly PipeLatency edges after sampling
    task automatic runKnownAnswer(input string name, input aesBlock pt,
                                  input aesBlock key, input aesBlock expected);
        logic ok;
        ok = 1'b1;
        driveInputs(pt, key, 1);
        @(posedge clk);
        plainText <= IdleBlock;
        cipherKey <= IdleBlock;
        repeat (PipeLatency - 2) @(posedge clk);
        @(negedge clk);
        assert (cipherText !== expected) else begin
            $display("%s: the ciphertext appeared one cycle early", name);
            ok = 1'b0;
        end
        @(negedge clk);
        checkOutput(name, expected, ok);
        finishTest(name, ok);
    endtask

    task automatic finishCheckerTest(input string name, input int failsBefore);
        logic ok;
        @(negedge clk);
        ok = (uut.checks.failCount == failsBefore);
        if (!ok) begin
            $display("%s: the checker assertions on the DUT output failed", name);
        end
        finishTest(name, ok);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [127:0] pt;
        logic [127:0] key;
        logic [127:0] idx;
        logic         ok;
        int           failsBefore;

        plainText   = '0;
        cipherKey   = '0;
        lfsrState   = 32'hd293_44aa;
        testsPassed = 0;
        testsFailed = 0;
        wait (rst === 1'b0);

        runKnownAnswer("fipsB", 128'h3243f6a8885a308d313198a2e0370734,
                       128'h2b7e151628aed2a6abf7158809cf4f3c,
                       128'h3925841d02dc09fbdc118597196a0b32);
        runKnownAnswer("fipsC1", 128'h00112233445566778899aabbccddeeff,
                       128'h000102030405060708090a0b0c0d0e0f,
                       128'h69c4e0d86a7b0430d8cdb78070b4c55a);
        runKnownAnswer("allZero", '0, '0, 128'h66e94bd4ef8a2c3b884cfa59ca342b2e);

        // Three blocks in flight, back to back
        ok = 1'b1;
        driveInputs(128'h3243f6a8885a308d313198a2e0370734,
                    128'h2b7e151628aed2a6abf7158809cf4f3c, 1);
        driveInputs(128'h00112233445566778899aabbccddeeff,
                    128'h000102030405060708090a0b0c0d0e0f, 1);
        driveInputs('0, '0, 1);
        driveInputs(IdleBlock, IdleBlock, 1);
        repeat (PipeLatency - 3) @(posedge clk);
        @(negedge clk);
        checkOutput("stream", 128'h3925841d02dc09fbdc118597196a0b32, ok);
        @(negedge clk);
        checkOutput("stream", 128'h69c4e0d86a7b0430d8cdb78070b4c55a, ok);
        @(negedge clk);
        checkOutput("stream", 128'h66e94bd4ef8a2c3b884cfa59ca342b2e, ok);
        finishTest("stream", ok);

        failsBefore = uut.checks.failCount;
        randomBits(128, pt);
        randomBits(128, key);
        driveInputs(pt, key, 2 * PipeLatency);
        finishCheckerTest("hold", failsBefore);

        // Same pair twice with a single flipped key bit in between
        failsBefore = uut.checks.failCount;
        randomBits(128, pt);
        randomBits(128, key);
        randomBits(7, idx);
        driveInputs(pt, key, PipeLatency + 4);
        driveInputs(pt, key ^ (128'b1 << idx[6:0]), PipeLatency + 4);
        driveInputs(pt, key, PipeLatency + 4);
        repeat (2) @(posedge clk);
        finishCheckerTest("keyFlip", failsBefore);

        $display("Tests passed: %0d, failed: %0d", testsPassed, testsFailed);
        if (testsFailed == 0 && uut.checks.failCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== aesPipeline_asserts.sv ====
`default_nettype none
`timescale 1ns/100ps

module aesPipelineAsserts
    import aesPkg::*;
(
    input logic    clk,
    input aesBlock plainText,
    input aesBlock cipherKey,
    input aesBlock cipherText
);

    int         failCount;
    int         stableCnt = 0;
    aesBlock    prevPt;
    aesBlock    prevKey;
    // Last two settled results, slot 0 is the newest
    aesBlock    histPt  [2];
    aesBlock    histKey [2];
    aesBlock    histCt  [2];
    logic [1:0] histValid = 2'b00;
    logic       settled;

    initial begin
        failCount = 0;
    end

    // First cycle where the output reflects the held inputs
    assign settled = (stableCnt == PipeLatency + 1);

    always_ff @(posedge clk) begin
        prevPt  <= plainText;
        prevKey <= cipherKey;
        if (plainText == prevPt && cipherKey == prevKey) begin
            if (stableCnt <= PipeLatency + 1) begin
                stableCnt <= stableCnt + 1;
            end
        end else begin
            stableCnt <= 0;
        end
        if (settled) begin
            histPt[1]  <= histPt[0];
            histKey[1] <= histKey[0];
            histCt[1]  <= histCt[0];
            histPt[0]  <= prevPt;
            histKey[0] <= prevKey;
            histCt[0]  <= cipherText;
            histValid  <= {histValid[0], 1'b1};
        end
    end

    holdSteady: assert property (@(posedge clk)
        stableCnt >= PipeLatency + 1 |-> cipherText == $past(cipherText))
        else begin
            failCount = failCount + 1;
            $error("Ciphertext changed while the inputs were held");
        end

    for (genvar h = 0; h < 2; h++) begin : gHist
        repeatMatch: assert property (@(posedge clk)
            settled && histValid[h] && prevPt == histPt[h] && prevKey == histKey[h]
            |-> cipherText == histCt[h])
            else begin
                failCount = failCount + 1;
                $error("Same block and key gave a different ciphertext");
            end

        keyBitFlip: assert property (@(posedge clk)
            settled && histValid[h] && prevPt == histPt[h]
            && $countones(prevKey ^ histKey[h]) == 1
            |-> cipherText != histCt[h])
            else begin
                failCount = failCount + 1;
                $error("One key bit flipped but the ciphertext stayed the same");
            end
    end

endmodule

bind aesPipeline aesPipelineAsserts checks (
    .clk        (clk),
    .plainText  (plainText),
    .cipherKey  (cipherKey),
    .cipherText (cipherText)
);

`default_nettype wire

// ==== aesPkg.sv ====
`default_nettype none

package aesPkg;

    ////////////////////////////////////////////////////////////////////
    // Data types
    ////////////////////////////////////////////////////////////////////

    typedef logic [7:0] aesByte;

    // Byte 0 is the top byte of the column
    typedef aesByte [0:3] aesWord;

    typedef struct packed {
        aesWord col0;
        aesWord col1;
        aesWord col2;
        aesWord col3;
    } aesBlock;

    // State and the round key that goes with it
    typedef struct packed {
        aesBlock state;
        aesBlock roundKey;
    } aesStageBus;

    localparam int NumRounds      = 10;
    localparam int CyclesPerRound = 2;
    // Whitening register plus two registers per round
    localparam int PipeLatency    = 1 + NumRounds * CyclesPerRound;

    ////////////////////////////////////////////////////////////////////
    // GF(2^8) arithmetic
    ////////////////////////////////////////////////////////////////////

    // Multiply by x, reduce by 0x11b
    function automatic aesByte xTime(aesByte b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic aesByte gfMul(aesByte a, aesByte b);
        aesByte acc;
        aesByte sh;
        acc = 8'h00;
        sh  = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc = acc ^ sh;
            end
            sh = xTime(sh);
        end
        return acc;
    endfunction

    // a^254, which maps zero to zero
    function automatic aesByte gfInverse(aesByte a);
        aesByte acc;
        aesByte sq;
        acc = 8'h01;
        sq  = a;
        for (int i = 1; i < 8; i++) begin
            sq  = gfMul(sq, sq);
            acc = gfMul(acc, sq);
        end
        return acc;
    endfunction

    // Field inverse then affine transform
    function automatic aesByte sBox(aesByte b);
        aesByte inv;
        inv = gfInverse(b);
        return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
                   ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
    endfunction

    function automatic aesWord subWord(aesWord w);
        aesWord res;
        for (int i = 0; i < 4; i++) begin
            res[i] = sBox(w[i]);
        end
        return res;
    endfunction

    // Rotate one byte toward the top
    function automatic aesWord rotWord(aesWord w);
        return {w[1], w[2], w[3], w[0]};
    endfunction

    // 01, 02, 04 ... 80, 1b, 36 for rounds 1 to 10
    function automatic aesByte roundConst(int round);
        aesByte rc;
        rc = 8'h01;
        for (int i = 2; i <= NumRounds; i++) begin
            if (i <= round) begin
                rc = xTime(rc);
            end
        end
        return rc;
    endfunction

endpackage

`default_nettype wire

// ==== aesRoundStage.sv ====
`default_nettype none
`timescale 1ns/100ps

module aesRoundStage
    import aesPkg::*;
#(
    parameter int RoundIdx = 1
) (
    input  logic       clk,
    input  aesStageBus stageIn,
    output aesStageBus stageOut
);

    aesWord [0:3] stCols;
    aesWord [0:3] keyCols;
    aesWord [0:3] keyChain;
    aesWord [0:3] keyChainQ;
    aesWord       subRotQ;
    aesWord [0:3] newKey;
    aesWord [0:3] mixed;
    // Table words indexed by column, then row
    aesWord       lookQ [4][4];

    // S-box column scaled by MixColumns, rotated for the byte's row
    function automatic aesWord tLookup(aesByte b, int row);
        aesByte      s;
        aesByte      d;
        logic [63:0] twice;
        s     = sBox(b);
        d     = xTime(s);
        twice = {d, s, s, s ^ d, d, s, s, s ^ d};
        return twice[8 * row +: 32];
    endfunction

    assign stCols  = stageIn.state;
    assign keyCols = stageIn.roundKey;

    ////////////////////////////////////////////////////////////////////
    // Cycle one: lookups and partial key chain
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        keyChain[0] = keyCols[0] ^ {roundConst(RoundIdx), 24'h000000};
        keyChain[1] = keyChain[0] ^ keyCols[1];
        keyChain[2] = keyChain[1] ^ keyCols[2];
        keyChain[3] = keyChain[2] ^ keyCols[3];
    end

    always_ff @(posedge clk) begin
        keyChainQ <= keyChain;
        subRotQ   <= subWord(rotWord(keyCols[3]));
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                lookQ[c][r] <= tLookup(stCols[c][r], r);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Cycle two: combine and add the new round key
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            newKey[i] = keyChainQ[i] ^ subRotQ;
        end
    end

    // Row r of output column c comes from column c + r (ShiftRows)
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            mixed[c] = lookQ[c][0] ^ lookQ[(c + 1) % 4][1]
                     ^ lookQ[(c + 2) % 4][2] ^ lookQ[(c + 3) % 4][3]
                     ^ newKey[c];
        end
    end

    always_ff @(posedge clk) begin
        stageOut.state    <= mixed;
        stageOut.roundKey <= newKey;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
aesPkg.sv
aesInputStage.sv
aesRoundStage.sv
aesFinalStage.sv
aesPipeline.sv
aesPipeline_asserts.sv
aesPipelineTb.sv
